//--- dbg_unit.f
+incdir+hdl
hdl/dbg_unit_pkg.sv
hdl/dbg_req_decode.sv
hdl/dbg_ctrl_regs.sv
hdl/dbg_halt_ctrl.sv
hdl/dbg_resp_mux.sv
hdl/dbg_unit.sv
testbench/tb_clk_gen.sv
testbench/dbg_unit_tb.sv

//--- hdl/dbg_ctrl_regs.sv
`timescale 1ns/10ps
`include "dbg_unit_defs.svh"

module dbg_ctrl_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    regs_we_i,
	input  dbg_unit_pkg::dbg_addr_t debug_addr_i,
	input  dbg_unit_pkg::word_t     debug_wdata_i,
	output dbg_unit_pkg::settings_t settings_o,
	output logic                    ssth_clear_o
);

	logic [4:0] idx;
	dbg_unit_pkg::settings_t settings_q;
	dbg_unit_pkg::settings_t settings_n;

	assign idx = debug_addr_i[`DBG_ADDR_IDX_MSB:`DBG_ADDR_IDX_LSB];

	////////////////////
	// write decode
	////////////////////

	always_comb begin
		settings_n = settings_q;
		// irq enable has no debugger field
		settings_n[`DBG_SETS_IRQ] = 1'b0;
		if (regs_we_i) begin
			case (idx)
				`DBG_IDX_CTRL: begin
					settings_n[`DBG_SETS_SSTE] = debug_wdata_i[`DBG_CTRL_SSTE_BIT];
				end
				`DBG_IDX_IE: begin
					settings_n[`DBG_SETS_ECALL] = debug_wdata_i[`DBG_IE_ECALL_BIT];
					// two elsu bits in the register, one enable
					settings_n[`DBG_SETS_ELSU] = debug_wdata_i[`DBG_IE_ELSU_BIT] |
						debug_wdata_i[`DBG_IE_ELSU2_BIT];
					settings_n[`DBG_SETS_EBRK] = debug_wdata_i[`DBG_IE_EBRK_BIT];
					settings_n[`DBG_SETS_EILL] = debug_wdata_i[`DBG_IE_EILL_BIT];
				end
				default: begin
					settings_n = settings_n;
				end
			endcase
		end
	end

	// write-one-to-clear on HIT bit 0
	assign ssth_clear_o = regs_we_i & (idx == `DBG_IDX_HIT) & debug_wdata_i[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n) begin
			settings_q <= '0;
		end else begin
			settings_q <= settings_n;
		end
	end

	assign settings_o = settings_q;

endmodule

//--- hdl/dbg_halt_ctrl.sv
`timescale 1ns/10ps
`include "dbg_unit_defs.svh"

module dbg_halt_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 halt_req_i,
	input  logic                 resume_req_i,
	input  logic                 debug_halt_i,
	input  logic                 debug_resume_i,
	input  logic                 trap_i,
	input  dbg_unit_pkg::cause_t exc_cause_i,
	input  logic                 sste_i,
	input  logic                 dbg_ack_i,
	input  logic                 ssth_clear_i,
	output logic                 dbg_req_o,
	output logic                 stall_o,
	output logic                 halted_o,
	output dbg_unit_pkg::cause_t cause_o,
	output logic                 ssth_o
);

	dbg_unit_pkg::halt_state_t state_q;
	dbg_unit_pkg::halt_state_t state_n;
	dbg_unit_pkg::cause_t cause_q;
	dbg_unit_pkg::cause_t cause_n;
	logic ssth_q;
	logic ssth_n;
	logic halt;
	logic resume;

	// debugger write, external halt pin or a trap
	assign halt = halt_req_i | debug_halt_i | trap_i;
	assign resume = resume_req_i | debug_resume_i;

	////////////////////
	// halt FSM
	////////////////////

	always_comb begin
		state_n = state_q;
		cause_n = cause_q;
		ssth_n = ssth_q;
		dbg_req_o = 1'b0;
		stall_o = 1'b0;
		halted_o = 1'b0;
		case (state_q)
			dbg_unit_pkg::HALT_IDLE: begin
				ssth_n = 1'b0;
				if (halt) begin
					dbg_req_o = 1'b1;
					state_n = dbg_unit_pkg::HALT_REQ;
					// trap wins over a halt in the same cycle
					if (trap_i) begin
						cause_n = exc_cause_i;
						ssth_n = sste_i;
					end else begin
						cause_n = `DBG_CAUSE_HALT;
					end
				end
			end
			dbg_unit_pkg::HALT_REQ: begin
				// hold the request until the core takes it
				dbg_req_o = 1'b1;
				if (dbg_ack_i) begin
					state_n = dbg_unit_pkg::HALT_STOPPED;
				end
				if (resume) begin
					state_n = dbg_unit_pkg::HALT_IDLE;
				end
			end
			dbg_unit_pkg::HALT_STOPPED: begin
				stall_o = 1'b1;
				halted_o = 1'b1;
				// release the stall without waiting for the edge
				if (resume) begin
					stall_o = 1'b0;
					state_n = dbg_unit_pkg::HALT_IDLE;
				end
			end
			default: begin
				state_n = dbg_unit_pkg::HALT_IDLE;
			end
		endcase
		if (ssth_clear_i) begin
			ssth_n = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n) begin
			state_q <= dbg_unit_pkg::HALT_IDLE;
			cause_q <= `DBG_CAUSE_HALT;
			ssth_q <= 1'b0;
		end else begin
			state_q <= state_n;
			cause_q <= cause_n;
			ssth_q <= ssth_n;
		end
	end

	assign cause_o = cause_q;
	assign ssth_o = ssth_q;

endmodule

//--- hdl/dbg_req_decode.sv
`timescale 1ns/10ps
`include "dbg_unit_defs.svh"

module dbg_req_decode (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     debug_req_i,
	input  dbg_unit_pkg::dbg_addr_t  debug_addr_i,
	input  logic                     debug_we_i,
	input  dbg_unit_pkg::word_t      debug_wdata_i,
	input  logic                     halted_i,
	output logic                     debug_gnt_o,
	output logic                     halt_req_o,
	output logic                     resume_req_o,
	output logic                     regs_we_o,
	output dbg_unit_pkg::rdata_sel_t rdata_sel_o,
	output dbg_unit_pkg::dbg_addr_t  addr_q_o,
	output logic                     regfile_rreq_o,
	output dbg_unit_pkg::reg_addr_t  regfile_raddr_o,
	output logic                     regfile_wreq_o,
	output dbg_unit_pkg::reg_addr_t  regfile_waddr_o,
	output dbg_unit_pkg::word_t      regfile_wdata_o,
	output logic                     jump_req_o,
	output dbg_unit_pkg::word_t      jump_addr_o
);

	logic [5:0] grp;
	logic [4:0] idx;
	logic wr;
	logic rd;
	logic is_regs;
	logic is_gpr;
	logic is_pc;
	logic is_ctrl;
	logic rreq_n;
	logic jump_n;
	dbg_unit_pkg::rdata_sel_t sel_n;
	logic pend_q;
	logic rreq_q;
	logic jump_q;
	dbg_unit_pkg::rdata_sel_t sel_q;
	dbg_unit_pkg::dbg_addr_t addr_q;
	dbg_unit_pkg::word_t wdata_q;

	////////////////////
	// request decode
	////////////////////

	assign grp = debug_addr_i[`DBG_ADDR_GRP_MSB:`DBG_ADDR_GRP_LSB];
	assign idx = debug_addr_i[`DBG_ADDR_IDX_MSB:`DBG_ADDR_IDX_LSB];
	assign wr = debug_req_i & debug_we_i;
	assign rd = debug_req_i & ~debug_we_i;

	assign is_regs = (grp == `DBG_GRP_REGS);
	assign is_gpr = (grp == `DBG_GRP_GPR);
	assign is_pc = (grp == `DBG_GRP_PC);
	assign is_ctrl = is_regs & (idx == `DBG_IDX_CTRL);

	// no wait states, every access is taken at once
	assign debug_gnt_o = debug_req_i;

	// CTRL halt bit only acts when it changes the run state
	assign halt_req_o = wr & is_ctrl & debug_wdata_i[`DBG_CTRL_HALT_BIT] & ~halted_i;
	assign resume_req_o = wr & is_ctrl & ~debug_wdata_i[`DBG_CTRL_HALT_BIT] & halted_i;
	assign regs_we_o = wr & is_regs;

	// GPR writes go straight to the core in the request cycle
	assign regfile_wreq_o = wr & is_gpr & halted_i;
	assign regfile_waddr_o = idx;
	assign regfile_wdata_o = debug_wdata_i;

	// next PC lives at index 0 of the PC group
	assign jump_n = wr & is_pc & (idx == 5'd0) & halted_i;
	assign rreq_n = rd & is_gpr & halted_i;

	always_comb begin
		sel_n = dbg_unit_pkg::SEL_NONE;
		if (rd) begin
			if (is_regs) begin
				sel_n = dbg_unit_pkg::SEL_DBG;
			end else if (is_pc) begin
				sel_n = dbg_unit_pkg::SEL_PC;
			end else if (is_gpr & halted_i) begin
				sel_n = dbg_unit_pkg::SEL_GPR;
			end
		end
	end

	////////////////////
	// stage register
	////////////////////

	// pend_q marks the response cycle of the previous access
	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n) begin
			pend_q <= 1'b0;
			sel_q <= dbg_unit_pkg::SEL_NONE;
			rreq_q <= 1'b0;
			jump_q <= 1'b0;
		end else begin
			pend_q <= debug_req_i;
			if (debug_req_i | pend_q) begin
				sel_q <= sel_n;
				rreq_q <= rreq_n;
				jump_q <= jump_n;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (debug_req_i) begin
			addr_q <= debug_addr_i;
			wdata_q <= debug_wdata_i;
		end
	end

	assign rdata_sel_o = sel_q;
	assign addr_q_o = addr_q;
	assign regfile_rreq_o = rreq_q;
	assign regfile_raddr_o = addr_q[`DBG_ADDR_IDX_MSB:`DBG_ADDR_IDX_LSB];
	assign jump_req_o = jump_q;
	assign jump_addr_o = wdata_q;

endmodule

//--- hdl/dbg_resp_mux.sv
`timescale 1ns/10ps
`include "dbg_unit_defs.svh"

module dbg_resp_mux (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     debug_gnt_i,
	input  dbg_unit_pkg::rdata_sel_t rdata_sel_i,
	input  dbg_unit_pkg::dbg_addr_t  addr_q_i,
	input  logic                     halted_i,
	input  logic                     sleeping_i,
	input  logic                     ssth_i,
	input  dbg_unit_pkg::settings_t  settings_i,
	input  dbg_unit_pkg::cause_t     cause_i,
	input  dbg_unit_pkg::word_t      pc_if_i,
	input  dbg_unit_pkg::word_t      pc_id_i,
	input  dbg_unit_pkg::word_t      regfile_rdata_i,
	output logic                     debug_rvalid_o,
	output dbg_unit_pkg::word_t      debug_rdata_o
);

	logic [4:0] idx;
	dbg_unit_pkg::word_t regs_img;
	dbg_unit_pkg::word_t pc_img;

	// one response per grant, reads and writes alike
	always_ff @(posedge clk or negedge rst_n) begin
		if (~rst_n) begin
			debug_rvalid_o <= 1'b0;
		end else begin
			debug_rvalid_o <= debug_gnt_i;
		end
	end

	assign idx = addr_q_i[`DBG_ADDR_IDX_MSB:`DBG_ADDR_IDX_LSB];

	////////////////////
	// register images
	////////////////////

	always_comb begin
		regs_img = '0;
		case (idx)
			`DBG_IDX_CTRL: begin
				regs_img[`DBG_CTRL_HALT_BIT] = halted_i;
				regs_img[`DBG_CTRL_SSTE_BIT] = settings_i[`DBG_SETS_SSTE];
			end
			`DBG_IDX_HIT: begin
				// sleep state at 16, step hit at 0
				regs_img[16] = sleeping_i;
				regs_img[0] = ssth_i;
			end
			`DBG_IDX_IE: begin
				regs_img[`DBG_IE_ECALL_BIT] = settings_i[`DBG_SETS_ECALL];
				regs_img[`DBG_IE_ELSU_BIT] = settings_i[`DBG_SETS_ELSU];
				regs_img[`DBG_IE_ELSU2_BIT] = settings_i[`DBG_SETS_ELSU];
				regs_img[`DBG_IE_EBRK_BIT] = settings_i[`DBG_SETS_EBRK];
				regs_img[`DBG_IE_EILL_BIT] = settings_i[`DBG_SETS_EILL];
			end
			`DBG_IDX_CAUSE: begin
				// interrupt flag on top, code in the low bits
				regs_img[31] = cause_i[5];
				regs_img[4:0] = cause_i[4:0];
			end
			default: begin
				regs_img = '0;
			end
		endcase
	end

	// bit 2 picks the previous PC
	assign pc_img = addr_q_i[`DBG_ADDR_PPC_BIT] ? pc_id_i : pc_if_i;

	always_comb begin
		case (rdata_sel_i)
			dbg_unit_pkg::SEL_GPR: debug_rdata_o = regfile_rdata_i;
			dbg_unit_pkg::SEL_DBG: debug_rdata_o = regs_img;
			dbg_unit_pkg::SEL_PC:  debug_rdata_o = pc_img;
			default:               debug_rdata_o = '0;
		endcase
	end

endmodule

//--- hdl/dbg_unit.sv
`timescale 1ns/10ps
`include "dbg_unit_defs.svh"

module dbg_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	// debugger bus
	input  logic                    debug_req_i,
	output logic                    debug_gnt_o,
	output logic                    debug_rvalid_o,
	input  dbg_unit_pkg::dbg_addr_t debug_addr_i,
	input  logic                    debug_we_i,
	input  dbg_unit_pkg::word_t     debug_wdata_i,
	output dbg_unit_pkg::word_t     debug_rdata_o,
	output logic                    debug_halted_o,
	input  logic                    debug_halt_i,
	input  logic                    debug_resume_i,
	// core side
	output dbg_unit_pkg::settings_t settings_o,
	input  logic                    trap_i,
	input  dbg_unit_pkg::cause_t    exc_cause_i,
	output logic                    stall_o,
	output logic                    dbg_req_o,
	input  logic                    dbg_ack_i,
	output logic                    regfile_rreq_o,
	output dbg_unit_pkg::reg_addr_t regfile_raddr_o,
	input  dbg_unit_pkg::word_t     regfile_rdata_i,
	output logic                    regfile_wreq_o,
	output dbg_unit_pkg::reg_addr_t regfile_waddr_o,
	output dbg_unit_pkg::word_t     regfile_wdata_o,
	input  dbg_unit_pkg::word_t     pc_if_i,
	input  dbg_unit_pkg::word_t     pc_id_i,
	input  logic                    sleeping_i,
	output logic                    jump_req_o,
	output dbg_unit_pkg::word_t     jump_addr_o
);

	logic halt_req;
	logic resume_req;
	logic regs_we;
	logic ssth_clear;
	logic ssth;
	dbg_unit_pkg::rdata_sel_t rdata_sel;
	dbg_unit_pkg::dbg_addr_t addr_q;
	dbg_unit_pkg::cause_t cause;

	////////////////////
	// bus request stage
	////////////////////

	dbg_req_decode dbg_req_decode_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.debug_req_i     (debug_req_i),
		.debug_addr_i    (debug_addr_i),
		.debug_we_i      (debug_we_i),
		.debug_wdata_i   (debug_wdata_i),
		.halted_i        (debug_halted_o),
		.debug_gnt_o     (debug_gnt_o),
		.halt_req_o      (halt_req),
		.resume_req_o    (resume_req),
		.regs_we_o       (regs_we),
		.rdata_sel_o     (rdata_sel),
		.addr_q_o        (addr_q),
		.regfile_rreq_o  (regfile_rreq_o),
		.regfile_raddr_o (regfile_raddr_o),
		.regfile_wreq_o  (regfile_wreq_o),
		.regfile_waddr_o (regfile_waddr_o),
		.regfile_wdata_o (regfile_wdata_o),
		.jump_req_o      (jump_req_o),
		.jump_addr_o     (jump_addr_o)
	);

	dbg_ctrl_regs dbg_ctrl_regs_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.regs_we_i     (regs_we),
		.debug_addr_i  (debug_addr_i),
		.debug_wdata_i (debug_wdata_i),
		.settings_o    (settings_o),
		.ssth_clear_o  (ssth_clear)
	);

	dbg_halt_ctrl dbg_halt_ctrl_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.halt_req_i     (halt_req),
		.resume_req_i   (resume_req),
		.debug_halt_i   (debug_halt_i),
		.debug_resume_i (debug_resume_i),
		.trap_i         (trap_i),
		.exc_cause_i    (exc_cause_i),
		.sste_i         (settings_o[`DBG_SETS_SSTE]),
		.dbg_ack_i      (dbg_ack_i),
		.ssth_clear_i   (ssth_clear),
		.dbg_req_o      (dbg_req_o),
		.stall_o        (stall_o),
		.halted_o       (debug_halted_o),
		.cause_o        (cause),
		.ssth_o         (ssth)
	);

	////////////////////
	// response stage
	////////////////////

	dbg_resp_mux dbg_resp_mux_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.debug_gnt_i     (debug_gnt_o),
		.rdata_sel_i     (rdata_sel),
		.addr_q_i        (addr_q),
		.halted_i        (debug_halted_o),
		.sleeping_i      (sleeping_i),
		.ssth_i          (ssth),
		.settings_i      (settings_o),
		.cause_i         (cause),
		.pc_if_i         (pc_if_i),
		.pc_id_i         (pc_id_i),
		.regfile_rdata_i (regfile_rdata_i),
		.debug_rvalid_o  (debug_rvalid_o),
		.debug_rdata_o   (debug_rdata_o)
	);

endmodule

//--- hdl/dbg_unit_defs.svh
`ifndef DBG_UNIT_DEFS_SVH
`define DBG_UNIT_DEFS_SVH

// address fields of the debug bus
`define DBG_ADDR_GRP_MSB 13
`define DBG_ADDR_GRP_LSB 8
`define DBG_ADDR_IDX_MSB 6
`define DBG_ADDR_IDX_LSB 2
`define DBG_ADDR_PPC_BIT 2

// register groups, addr[13:8]
`define DBG_GRP_REGS 6'h00
`define DBG_GRP_GPR  6'h04
`define DBG_GRP_PC   6'h20

// debug register indexes, addr[6:2]
`define DBG_IDX_CTRL  5'd0
`define DBG_IDX_HIT   5'd1
`define DBG_IDX_IE    5'd2
`define DBG_IDX_CAUSE 5'd3

// control register bits
`define DBG_CTRL_HALT_BIT 16
`define DBG_CTRL_SSTE_BIT 0

// trap-enable register bits
`define DBG_IE_ECALL_BIT 11
`define DBG_IE_ELSU_BIT  7
`define DBG_IE_ELSU2_BIT 5
`define DBG_IE_EBRK_BIT  3
`define DBG_IE_EILL_BIT  2

// settings vector bit positions
`define DBG_SETS_IRQ   5
`define DBG_SETS_ECALL 4
`define DBG_SETS_EILL  3
`define DBG_SETS_ELSU  2
`define DBG_SETS_EBRK  1
`define DBG_SETS_SSTE  0

// cause code of a debugger halt
`define DBG_CAUSE_HALT 6'h1F

`endif

//--- hdl/dbg_unit_pkg.sv
package dbg_unit_pkg;

	// data word, also used for PC values
	typedef logic [31:0] word_t;

	// debug bus address, group in [13:8], index in [6:2]
	typedef logic [13:0] dbg_addr_t;

	// register file index
	typedef logic [4:0] reg_addr_t;

	// debug or exception cause
	typedef logic [5:0] cause_t;

	// trap enables and single-step, sent to the core
	typedef logic [5:0] settings_t;

	////////////////////
	// state machines
	////////////////////

	typedef enum logic [1:0] {
		HALT_IDLE,
		HALT_REQ,
		HALT_STOPPED
	} halt_state_t;

	// source of the read data in the response stage
	typedef enum logic [1:0] {
		SEL_NONE,
		SEL_GPR,
		SEL_DBG,
		SEL_PC
	} rdata_sel_t;

endpackage

//--- testbench/dbg_unit_tb.sv
`timescale 1ns/10ps
`include "dbg_unit_defs.svh"

module dbg_unit_tb;

	localparam int ACCESS_COUNT = 40;
	localparam int CYCLES_PER_ACCESS = 20;
	localparam int MARGIN_CYCLES = 100;

	logic clk;
	logic rst_n;
	logic debug_req;
	logic debug_gnt;
	logic debug_rvalid;
	dbg_unit_pkg::dbg_addr_t debug_addr;
	logic debug_we;
	dbg_unit_pkg::word_t debug_wdata;
	dbg_unit_pkg::word_t debug_rdata;
	logic debug_halted;
	logic debug_halt;
	logic debug_resume;
	dbg_unit_pkg::settings_t settings;
	logic trap;
	dbg_unit_pkg::cause_t exc_cause;
	logic stall;
	logic dbg_req;
	logic dbg_ack;
	logic regfile_rreq;
	dbg_unit_pkg::reg_addr_t regfile_raddr;
	dbg_unit_pkg::word_t regfile_rdata;
	logic regfile_wreq;
	dbg_unit_pkg::reg_addr_t regfile_waddr;
	dbg_unit_pkg::word_t regfile_wdata;
	dbg_unit_pkg::word_t pc_if;
	dbg_unit_pkg::word_t pc_id;
	logic sleeping;
	logic jump_req;
	dbg_unit_pkg::word_t jump_addr;

	integer seed = 32'h2c22fad6;
	int error_count = 0;
	string test_name = "none";

	// expected state of the unit
	logic m_halted;
	logic m_sste;
	logic m_ecall;
	logic m_eill;
	logic m_elsu;
	logic m_ebrk;
	logic m_hit;
	dbg_unit_pkg::cause_t m_cause;
	dbg_unit_pkg::word_t m_pc_if;
	dbg_unit_pkg::word_t m_pc_id;
	dbg_unit_pkg::word_t exp_rf [32];
	dbg_unit_pkg::word_t rf_model [32];

	// accesses granted and still waiting for rvalid
	dbg_unit_pkg::dbg_addr_t pend_addr [$];
	logic pend_we [$];
	string pend_name [$];

	tb_clk_gen clk_gen_inst (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	dbg_unit dbg_unit_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.debug_req_i     (debug_req),
		.debug_gnt_o     (debug_gnt),
		.debug_rvalid_o  (debug_rvalid),
		.debug_addr_i    (debug_addr),
		.debug_we_i      (debug_we),
		.debug_wdata_i   (debug_wdata),
		.debug_rdata_o   (debug_rdata),
		.debug_halted_o  (debug_halted),
		.debug_halt_i    (debug_halt),
		.debug_resume_i  (debug_resume),
		.settings_o      (settings),
		.trap_i          (trap),
		.exc_cause_i     (exc_cause),
		.stall_o         (stall),
		.dbg_req_o       (dbg_req),
		.dbg_ack_i       (dbg_ack),
		.regfile_rreq_o  (regfile_rreq),
		.regfile_raddr_o (regfile_raddr),
		.regfile_rdata_i (regfile_rdata),
		.regfile_wreq_o  (regfile_wreq),
		.regfile_waddr_o (regfile_waddr),
		.regfile_wdata_o (regfile_wdata),
		.pc_if_i         (pc_if),
		.pc_id_i         (pc_id),
		.sleeping_i      (sleeping),
		.jump_req_o      (jump_req),
		.jump_addr_o     (jump_addr)
	);

	////////////////////
	// reference model
	////////////////////

	function automatic dbg_unit_pkg::word_t fill_word(input int i);
		return 32'hC0DE0000 + i * 32'h00000111;
	endfunction

	function automatic dbg_unit_pkg::dbg_addr_t make_addr(input logic [5:0] grp,
			input logic [4:0] idx);
		return {grp, 1'b0, idx, 2'b00};
	endfunction

	function automatic dbg_unit_pkg::settings_t expected_settings();
		dbg_unit_pkg::settings_t s;
		s = '0;
		s[4] = m_ecall;
		s[3] = m_eill;
		s[2] = m_elsu;
		s[1] = m_ebrk;
		s[0] = m_sste;
		return s;
	endfunction

	function automatic dbg_unit_pkg::word_t expected_read(input dbg_unit_pkg::dbg_addr_t addr);
		logic [5:0] grp;
		logic [4:0] idx;
		dbg_unit_pkg::word_t value;
		grp = addr[13:8];
		idx = addr[6:2];
		value = '0;
		if (grp == `DBG_GRP_REGS) begin
			case (idx)
				`DBG_IDX_CTRL: begin
					value[16] = m_halted;
					value[0] = m_sste;
				end
				`DBG_IDX_HIT: begin
					value[16] = sleeping;
					value[0] = m_hit;
				end
				`DBG_IDX_IE: begin
					value[11] = m_ecall;
					value[7] = m_elsu;
					value[5] = m_elsu;
					value[3] = m_ebrk;
					value[2] = m_eill;
				end
				`DBG_IDX_CAUSE: begin
					value[31] = m_cause[5];
					value[4:0] = m_cause[4:0];
				end
				default: begin
					value = '0;
				end
			endcase
		end else if (grp == `DBG_GRP_PC) begin
			value = addr[2] ? m_pc_id : m_pc_if;
		end else if (grp == `DBG_GRP_GPR && m_halted) begin
			value = exp_rf[idx];
		end
		return value;
	endfunction

	// state change that a write causes, apart from halt and resume
	task automatic apply_write(input dbg_unit_pkg::dbg_addr_t addr,
			input dbg_unit_pkg::word_t data);
		if (addr[13:8] == `DBG_GRP_REGS) begin
			if (addr[6:2] == `DBG_IDX_CTRL) begin
				m_sste = data[0];
			end else if (addr[6:2] == `DBG_IDX_HIT && data[0]) begin
				m_hit = 1'b0;
			end else if (addr[6:2] == `DBG_IDX_IE) begin
				m_ecall = data[11];
				m_elsu = data[7] | data[5];
				m_ebrk = data[3];
				m_eill = data[2];
			end
		end else if (addr[13:8] == `DBG_GRP_GPR && m_halted) begin
			exp_rf[addr[6:2]] = data;
		end
	endtask

	////////////////////
	// checks
	////////////////////

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("[FAIL] %s / %s: expected 0x%08h, actual 0x%08h",
				test_name, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("error in %s: %s", test_name, msg);
		stop_with_failure();
	endtask

	////////////////////
	// bus tasks
	////////////////////

	// called at a falling edge, returns at the next one with req still high
	task automatic bus_cycle(input logic we, input dbg_unit_pkg::dbg_addr_t addr,
			input dbg_unit_pkg::word_t data, input string name);
		debug_req = 1'b1;
		debug_we = we;
		debug_addr = addr;
		debug_wdata = data;
		#5;
		check_value({name, " grant"}, 1, debug_gnt);
		pend_addr.push_back(addr);
		pend_we.push_back(we);
		pend_name.push_back(name);
		@(negedge clk);
		if (we) begin
			apply_write(addr, data);
		end
	endtask

	task automatic bus_release();
		debug_req = 1'b0;
		debug_we = 1'b0;
	endtask

	task automatic wait_responses();
		while (pend_addr.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic write_reg(input dbg_unit_pkg::dbg_addr_t addr, input dbg_unit_pkg::word_t data,
			input string name);
		bus_cycle(1'b1, addr, data, name);
		bus_release();
		wait_responses();
	endtask

	task automatic read_reg(input dbg_unit_pkg::dbg_addr_t addr, input string name);
		bus_cycle(1'b0, addr, '0, name);
		bus_release();
		wait_responses();
	endtask

	// GPR write with the regfile port checked in the request cycle
	task automatic gpr_write(input logic [4:0] idx, input dbg_unit_pkg::word_t data,
			input logic expect_req);
		fork
			bus_cycle(1'b1, make_addr(`DBG_GRP_GPR, idx), data, "gpr write");
			begin
				#5;
				check_value("regfile_wreq", expect_req, regfile_wreq);
				if (expect_req) begin
					check_value("regfile_waddr", idx, regfile_waddr);
					check_value("regfile_wdata", data, regfile_wdata);
				end
			end
		join
		bus_release();
		wait_responses();
	endtask

	// dbg_req held until the ack, then halted one edge later
	task automatic wait_halt();
		bit done;
		done = 1'b0;
		for (int i = 0; i < 10 && !done; i++) begin
			@(posedge clk);
			#5;
			if (dbg_ack) begin
				check_value("halted after ack", 1, debug_halted);
				check_value("stall after ack", 1, stall);
				check_value("dbg_req after ack", 0, dbg_req);
				done = 1'b1;
			end else begin
				check_value("dbg_req held", 1, dbg_req);
				check_value("halted before ack", 0, debug_halted);
			end
		end
		if (!done) begin
			report_error("the core never acknowledged the halt request");
		end
		@(negedge clk);
		m_halted = 1'b1;
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic run_reset_test();
		test_name = "reset";
		check_value("halted", 0, debug_halted);
		check_value("stall", 0, stall);
		check_value("dbg_req", 0, dbg_req);
		check_value("settings", 0, settings);
		check_value("jump_req", 0, jump_req);
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CAUSE), "cause");
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CTRL), "ctrl");
		// back to back, one rvalid per grant
		bus_cycle(1'b0, make_addr(6'h3F, 5'd0), '0, "unmapped group 3f");
		bus_cycle(1'b0, make_addr(6'h01, 5'd7), '0, "unmapped group 01");
		bus_cycle(1'b0, make_addr(`DBG_GRP_REGS, 5'd9), '0, "unmapped index");
		bus_cycle(1'b0, make_addr(`DBG_GRP_REGS, `DBG_IDX_CAUSE), '0, "cause in burst");
		bus_release();
		wait_responses();
	endtask

	task automatic run_ie_test();
		dbg_unit_pkg::word_t data;
		test_name = "trap enable";
		for (int i = 0; i < 4; i++) begin
			// first pass sets only the second elsu bit
			data = (i == 0) ? 32'h0000_0020 : $random(seed);
			write_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_IE), data, "ie write");
			check_value("settings", expected_settings(), settings);
			read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_IE), "ie read");
		end
	endtask

	task automatic run_halt_test();
		test_name = "halt";
		write_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CTRL), 32'h0001_0000, "ctrl halt");
		m_cause = `DBG_CAUSE_HALT;
		wait_halt();
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CTRL), "ctrl halted");
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CAUSE), "cause halt");
	endtask

	task automatic run_gpr_halted_test();
		logic [4:0] idx [4];
		test_name = "gpr halted";
		for (int i = 0; i < 4; i++) begin
			idx[i] = $random(seed);
			gpr_write(idx[i], $random(seed), 1'b1);
		end
		for (int i = 0; i < 4; i++) begin
			read_reg(make_addr(`DBG_GRP_GPR, idx[i]), "gpr read");
		end
		read_reg(make_addr(`DBG_GRP_GPR, 5'd31), "gpr read 31");
	endtask

	task automatic run_pc_test();
		dbg_unit_pkg::word_t data;
		test_name = "pc";
		m_pc_if = $random(seed);
		m_pc_id = $random(seed);
		pc_if = m_pc_if;
		pc_id = m_pc_id;
		read_reg(make_addr(`DBG_GRP_PC, 5'd0), "npc read");
		read_reg(make_addr(`DBG_GRP_PC, 5'd1), "ppc read");
		data = $random(seed);
		fork
			bus_cycle(1'b1, make_addr(`DBG_GRP_PC, 5'd0), data, "npc write");
			begin
				#5;
				check_value("jump_req in request cycle", 0, jump_req);
				#10;
				check_value("jump_req", 1, jump_req);
				check_value("jump_addr", data, jump_addr);
			end
		join
		bus_release();
		wait_responses();
	endtask

	task automatic run_resume_test();
		test_name = "resume";
		fork
			write_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CTRL), 32'h0, "ctrl resume");
			begin
				#5;
				check_value("stall in resume cycle", 0, stall);
				check_value("halted in resume cycle", 1, debug_halted);
			end
		join
		check_value("halted after resume", 0, debug_halted);
		check_value("stall after resume", 0, stall);
		m_halted = 1'b0;
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CTRL), "ctrl running");
	endtask

	task automatic run_gpr_running_test();
		test_name = "gpr running";
		gpr_write(5'd3, $random(seed), 1'b0);
		read_reg(make_addr(`DBG_GRP_GPR, 5'd3), "gpr read running");
	endtask

	task automatic run_trap_test();
		dbg_unit_pkg::cause_t cause_val;
		test_name = "trap step";
		write_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CTRL), 32'h1, "ctrl sste");
		// top cause bit set so that bit 31 is exercised
		cause_val = $random(seed) | 6'h20;
		trap = 1'b1;
		exc_cause = cause_val;
		m_cause = cause_val;
		m_hit = m_sste;
		@(negedge clk);
		trap = 1'b0;
		wait_halt();
		sleeping = 1'b1;
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_HIT), "hit set");
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CAUSE), "cause trap");
		// written while running, must be unchanged
		read_reg(make_addr(`DBG_GRP_GPR, 5'd3), "gpr kept");
		write_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_HIT), 32'h1, "hit clear");
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_HIT), "hit cleared");
		sleeping = 1'b0;
		debug_resume = 1'b1;
		#5;
		check_value("stall on resume pin", 0, stall);
		@(negedge clk);
		debug_resume = 1'b0;
		m_halted = 1'b0;
		#5;
		check_value("halted after resume pin", 0, debug_halted);
		@(negedge clk);
		read_reg(make_addr(`DBG_GRP_REGS, `DBG_IDX_CTRL), "ctrl after trap");
	endtask

	////////////////////
	// core model
	////////////////////

	assign regfile_rdata = rf_model[regfile_raddr];

	always @(posedge clk) begin
		if (regfile_wreq) begin
			rf_model[regfile_waddr] <= regfile_wdata;
		end
	end

	// ack the halt request after 0 to 5 cycles
	initial begin : core_ack
		int delay;
		forever begin
			@(posedge clk);
			#5;
			if (dbg_req) begin
				delay = $unsigned($random(seed)) % 6;
				repeat (delay) @(negedge clk);
				@(negedge clk);
				dbg_ack = 1'b1;
				@(negedge clk);
				dbg_ack = 1'b0;
			end
		end
	end

	// every grant must see rvalid in the next cycle
	initial begin : compare_responses
		dbg_unit_pkg::dbg_addr_t addr;
		logic we;
		string name;
		forever begin
			@(posedge clk);
			#5;
			if (debug_rvalid) begin
				if (pend_addr.size() == 0) begin
					report_error("rvalid arrived with no access in flight");
				end else begin
					addr = pend_addr.pop_front();
					we = pend_we.pop_front();
					name = pend_name.pop_front();
					if (!we) begin
						check_value(name, expected_read(addr), debug_rdata);
						if (addr[13:8] == `DBG_GRP_GPR) begin
							check_value({name, " rreq"}, m_halted, regfile_rreq);
							if (m_halted) begin
								check_value({name, " raddr"}, addr[6:2], regfile_raddr);
							end
						end
					end
				end
			end else if (pend_addr.size() != 0) begin
				report_error("no rvalid in the cycle after a grant");
			end
		end
	end

	initial begin : watchdog
		repeat (ACCESS_COUNT * CYCLES_PER_ACCESS + MARGIN_CYCLES) @(posedge clk);
		$display("timeout: the run hung and did not finish in time");
		stop_with_failure();
	end

	initial begin : stimulus
		debug_req = 1'b0;
		debug_addr = '0;
		debug_we = 1'b0;
		debug_wdata = '0;
		debug_halt = 1'b0;
		debug_resume = 1'b0;
		trap = 1'b0;
		exc_cause = '0;
		dbg_ack = 1'b0;
		pc_if = '0;
		pc_id = '0;
		sleeping = 1'b0;
		m_halted = 1'b0;
		m_sste = 1'b0;
		m_ecall = 1'b0;
		m_eill = 1'b0;
		m_elsu = 1'b0;
		m_ebrk = 1'b0;
		m_hit = 1'b0;
		m_cause = `DBG_CAUSE_HALT;
		m_pc_if = '0;
		m_pc_id = '0;
		for (int i = 0; i < 32; i++) begin
			rf_model[i] = fill_word(i);
			exp_rf[i] = fill_word(i);
		end
		@(posedge rst_n);
		@(negedge clk);
		run_reset_test();
		run_ie_test();
		run_halt_test();
		run_gpr_halted_test();
		run_pc_test();
		run_resume_test();
		run_gpr_running_test();
		run_trap_test();
		if (error_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			stop_with_failure();
		end
	end

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule
